// File: dbg_pkg.sv
`default_nettype none

package dbg_pkg;

	////////////////////////////////////////
	// Link and pipeline widths
	////////////////////////////////////////

	// One byte on the serial link
	typedef logic [7:0] byte_t;

	// Program counter of one stage
	typedef logic [8:0] pc_t;

	// Pipeline cycle count since the last clear
	typedef logic [15:0] cycle_t;

	////////////////////////////////////////
	// Snapshot stream
	////////////////////////////////////////

	// Four pcs and the cycle count, two bytes each
	localparam int SNAP_BYTES = 10;

	// Byte index within the snapshot
	typedef logic [3:0] snap_idx_t;

	// Command bytes from the host
	localparam byte_t CMD_RUN = 8'h63;
	localparam byte_t CMD_STEP = 8'h70;
	localparam byte_t CMD_CLEAR = 8'h72;

	////////////////////////////////////////
	// Controller FSM
	////////////////////////////////////////

	typedef enum logic [2:0] {
		// Waiting for a command byte
		IDLE,
		// Pop the receive FIFO
		READ,
		// Decode and issue step or clear
		EXEC,
		// Free run until the program ends
		RUN,
		// Freeze pipeline state
		CAPTURE,
		// Stream the snapshot out
		SEND
	} ctrl_state_t;

endpackage

`default_nettype wire

// File: snap_if.sv
`timescale 1ns/10ps
`default_nettype none

interface snap_if;

	// Stage pcs, fetch first
	dbg_pkg::pc_t pcf;
	dbg_pkg::pc_t pcd;
	dbg_pkg::pc_t pce;
	dbg_pkg::pc_t pcw;

	// Advances since clear
	dbg_pkg::cycle_t cycles;

	// Last instruction reached writeback
	logic halted;

	// Pipeline model side
	modport pipe (
		output pcf, pcd, pce, pcw, cycles, halted
	);

	// Snapshot capture side
	modport buff (
		input pcf, pcd, pce, pcw, cycles
	);

	// Controller only watches for program end
	modport ctrl (
		input halted
	);

endinterface

`default_nettype wire

// File: pc_pipe.sv
`timescale 1ns/10ps
`default_nettype none

module pc_pipe #(
	parameter int PROG_LEN = 40
) (
	input logic clk,
	input logic rst_n,
	input logic step,
	input logic run,
	input logic clear,
	snap_if.pipe snap
);

	// Pc of the final instruction
	localparam dbg_pkg::pc_t LAST_PC = dbg_pkg::pc_t'(PROG_LEN - 1);

	logic primed;
	logic advance;

	////////////////////////////////////////
	// Halt detection
	////////////////////////////////////////

	// Execute and writeback only differ once the pipe is full
	assign primed = (snap.pce != snap.pcw);

	// Writeback holding the last pc ends the program
	assign snap.halted = primed && (snap.pcw == LAST_PC);

	// Step pulse or run level moves the pipe unless halted
	assign advance = (step || run) && !snap.halted;

	////////////////////////////////////////
	// Stage registers
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n || clear)
		begin
			// Empty pipe, counter back to zero
			snap.pcf <= '0;
			snap.pcd <= '0;
			snap.pce <= '0;
			snap.pcw <= '0;
			snap.cycles <= '0;
		end
		else if (advance)
		begin
			// Each pc moves one stage toward writeback
			snap.pcw <= snap.pce;
			snap.pce <= snap.pcd;
			snap.pcd <= snap.pcf;
			// Sequential fetch
			snap.pcf <= snap.pcf + 1'b1;
			snap.cycles <= snap.cycles + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: snapshot_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module snapshot_buffer (
	input logic clk,
	input logic rst_n,
	input logic capture,
	snap_if.buff snap,
	input dbg_pkg::snap_idx_t idx,
	output dbg_pkg::byte_t data
);

	// Frozen snapshot bytes
	dbg_pkg::byte_t snap_q [dbg_pkg::SNAP_BYTES];
	// Live pipeline state in link byte order
	dbg_pkg::byte_t snap_d [dbg_pkg::SNAP_BYTES];

	////////////////////////////////////////
	// Byte layout
	////////////////////////////////////////

	// Low byte first for every field
	// High byte of a pc carries only bit 8
	always_comb
	begin
		snap_d[0] = snap.pcf[7:0];
		snap_d[1] = {7'b0, snap.pcf[8]};
		snap_d[2] = snap.pcd[7:0];
		snap_d[3] = {7'b0, snap.pcd[8]};
		snap_d[4] = snap.pce[7:0];
		snap_d[5] = {7'b0, snap.pce[8]};
		snap_d[6] = snap.pcw[7:0];
		snap_d[7] = {7'b0, snap.pcw[8]};
		snap_d[8] = snap.cycles[7:0];
		snap_d[9] = snap.cycles[15:8];
	end

	////////////////////////////////////////
	// Capture register
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < dbg_pkg::SNAP_BYTES; i++)
			begin
				snap_q[i] <= '0;
			end
		end
		else if (capture)
		begin
			// Whole snapshot in one edge
			snap_q <= snap_d;
		end
	end

	// Read port for the transmit stream
	assign data = (idx < dbg_pkg::SNAP_BYTES) ? snap_q[idx] : '0;

endmodule

`default_nettype wire

// File: debug_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module debug_ctrl (
	input logic clk,
	input logic rst_n,
	input dbg_pkg::byte_t r_data,
	input logic rx_empty,
	input logic tx_full,
	output dbg_pkg::byte_t w_data,
	output logic rd,
	output logic wr,
	output logic step,
	output logic run,
	output logic clear,
	output logic capture,
	output dbg_pkg::snap_idx_t idx,
	input dbg_pkg::byte_t data,
	snap_if.ctrl snap
);

	// Index of the final snapshot byte
	localparam dbg_pkg::snap_idx_t LAST_IDX = dbg_pkg::snap_idx_t'(dbg_pkg::SNAP_BYTES - 1);

	dbg_pkg::ctrl_state_t state;
	dbg_pkg::ctrl_state_t state_nxt;
	// Command byte under execution
	dbg_pkg::byte_t cmd;

	////////////////////////////////////////
	// State register
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			state <= dbg_pkg::IDLE;
		else
			state <= state_nxt;
	end

	// Latch the byte while it is popped
	always_ff @(posedge clk)
	begin
		if (state == dbg_pkg::READ)
			cmd <= r_data;
	end

	////////////////////////////////////////
	// Next state
	////////////////////////////////////////

	always_comb
	begin
		state_nxt = state;
		case (state)
			dbg_pkg::IDLE:
			begin
				// Show-ahead FIFO so data is already valid
				if (!rx_empty)
					state_nxt = dbg_pkg::READ;
			end
			dbg_pkg::READ:
				state_nxt = dbg_pkg::EXEC;
			dbg_pkg::EXEC:
			begin
				case (cmd)
					dbg_pkg::CMD_RUN:
						state_nxt = dbg_pkg::RUN;
					dbg_pkg::CMD_STEP,
					dbg_pkg::CMD_CLEAR:
						state_nxt = dbg_pkg::CAPTURE;
					// Unknown bytes are dropped silently
					default:
						state_nxt = dbg_pkg::IDLE;
				endcase
			end
			dbg_pkg::RUN:
			begin
				if (snap.halted)
					state_nxt = dbg_pkg::CAPTURE;
			end
			dbg_pkg::CAPTURE:
				state_nxt = dbg_pkg::SEND;
			dbg_pkg::SEND:
			begin
				// Done after the tenth accepted byte
				if (wr && (idx == LAST_IDX))
					state_nxt = dbg_pkg::IDLE;
			end
			default:
				state_nxt = dbg_pkg::IDLE;
		endcase
	end

	////////////////////////////////////////
	// Snapshot byte counter
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n || (state == dbg_pkg::CAPTURE))
			idx <= '0;
		else if (wr)
			idx <= idx + 1'b1;
	end

	////////////////////////////////////////
	// Strobes
	////////////////////////////////////////

	assign rd = (state == dbg_pkg::READ);
	// One-cycle pulses out of EXEC
	assign step = (state == dbg_pkg::EXEC) && (cmd == dbg_pkg::CMD_STEP);
	assign clear = (state == dbg_pkg::EXEC) && (cmd == dbg_pkg::CMD_CLEAR);
	// Held for the whole run
	assign run = (state == dbg_pkg::RUN);
	assign capture = (state == dbg_pkg::CAPTURE);
	// Hold off while the transmit FIFO is full
	assign wr = (state == dbg_pkg::SEND) && !tx_full;
	assign w_data = data;

endmodule

`default_nettype wire

// File: debug_unit.sv
`timescale 1ns/10ps
`default_nettype none

module debug_unit #(
	parameter int PROG_LEN = 40
) (
	input logic clk,
	input logic rst_n,
	input dbg_pkg::byte_t r_data,
	input logic rx_empty,
	input logic tx_full,
	output dbg_pkg::byte_t w_data,
	output logic rd,
	output logic wr
);

	////////////////////////////////////////
	// Internal nets
	////////////////////////////////////////

	// Pipeline state shared by all three blocks
	snap_if snap ();

	// Pipeline control
	logic step;
	logic run;
	logic clear;

	// Snapshot access
	logic capture;
	dbg_pkg::snap_idx_t idx;
	dbg_pkg::byte_t data;

	////////////////////////////////////////
	// Blocks
	////////////////////////////////////////

	// Processor pc pipeline model
	pc_pipe #(
		.PROG_LEN(PROG_LEN)
	) u_pc_pipe (
		.clk(clk),
		.rst_n(rst_n),
		.step(step),
		.run(run),
		.clear(clear),
		.snap(snap.pipe)
	);

	// Frozen copy for the transmit stream
	snapshot_buffer u_snapshot_buffer (
		.clk(clk),
		.rst_n(rst_n),
		.capture(capture),
		.snap(snap.buff),
		.idx(idx),
		.data(data)
	);

	// Command FSM between the FIFOs and the pipeline
	debug_ctrl u_debug_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.r_data(r_data),
		.rx_empty(rx_empty),
		.tx_full(tx_full),
		.w_data(w_data),
		.rd(rd),
		.wr(wr),
		.step(step),
		.run(run),
		.clear(clear),
		.capture(capture),
		.idx(idx),
		.data(data),
		.snap(snap.ctrl)
	);

endmodule

`default_nettype wire

// File: tb_debug_unit_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module tb_debug_unit_asserts (
	input logic clk,
	input logic rst_n,
	input logic rx_empty,
	input logic tx_full,
	input logic rd,
	input logic wr,
	input dbg_pkg::snap_idx_t idx
);

	// Count of failed assertions
	int fail_count = 0;

	////////////////////////////////////////
	// Transmit side
	////////////////////////////////////////

	// Never push into a full FIFO
	a_wr_not_full: assert property (@(posedge clk) disable iff (!rst_n)
		wr |-> !tx_full)
	else
	begin
		$error("wr issued while tx_full high");
		fail_count++;
	end

	// Stream stops after the tenth byte
	a_wr_last: assert property (@(posedge clk) disable iff (!rst_n)
		(wr && (idx == dbg_pkg::SNAP_BYTES - 1)) |=> !wr)
	else
	begin
		$error("wr continued past the last snapshot byte");
		fail_count++;
	end

	////////////////////////////////////////
	// Receive side
	////////////////////////////////////////

	// Pop only after the FIFO showed data
	a_rd_after_data: assert property (@(posedge clk) disable iff (!rst_n)
		rd |-> $past(!rx_empty))
	else
	begin
		$error("rd without rx_empty low the cycle before");
		fail_count++;
	end

	// One pop per command byte
	a_rd_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		rd |=> !rd)
	else
	begin
		$error("rd held longer than one cycle");
		fail_count++;
	end

	// Link directions never overlap
	a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(rd && wr))
	else
	begin
		$error("rd and wr high together");
		fail_count++;
	end

endmodule

`default_nettype wire

// File: tb_debug_unit.sv
`timescale 1ns/10ps
`default_nettype none

module tb_debug_unit;

	localparam int PROG_LEN = 40;
	// Advances until writeback holds the last pc
	localparam int HALT_K = PROG_LEN + 2;
	localparam int TIMEOUT = 400;

	logic clk;
	logic rst_n;
	dbg_pkg::byte_t r_data;
	logic rx_empty;
	logic tx_full;
	dbg_pkg::byte_t w_data;
	logic rd;
	logic wr;

	// FIFO models
	dbg_pkg::byte_t rx_q [$];
	dbg_pkg::byte_t tx_q [$];
	logic pop_pending;
	// Random back-pressure on tx_full
	logic bp_en;
	logic [31:0] lfsr;
	// Reference model counts advances since clear
	int k;

	debug_unit DUT (
		.clk(clk),
		.rst_n(rst_n),
		.r_data(r_data),
		.rx_empty(rx_empty),
		.tx_full(tx_full),
		.w_data(w_data),
		.rd(rd),
		.wr(wr)
	);

	bind debug_ctrl tb_debug_unit_asserts u_asserts (
		.clk(clk),
		.rst_n(rst_n),
		.rx_empty(rx_empty),
		.tx_full(tx_full),
		.rd(rd),
		.wr(wr),
		.idx(idx)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("Mismatch at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "Stopping at first error");
		end
	endtask

	// Byte i of the snapshot after kk advances
	function automatic int expected_byte(input int kk, input int i);
		int v;
		if (i >= 8)
			v = kk;
		else
		begin
			// Stage n lags fetch by n
			v = kk - i / 2;
			if (v < 0)
				v = 0;
		end
		// Low byte first
		return (i % 2 == 0) ? (v & 8'hff) : ((v >> 8) & 8'hff);
	endfunction

	////////////////////////////////////////
	// FIFO models
	////////////////////////////////////////

	// Outputs are stable at the falling edge
	always @(negedge clk)
	begin
		if (DUT.u_debug_ctrl.u_asserts.fail_count != 0)
		begin
			$display("A FIFO strobe assertion failed");
			$display("TEST FAILED");
			$fatal(1, "Assertion failure");
		end
		if (rst_n)
		begin
			if (rd)
				pop_pending = 1'b1;
			if (wr)
			begin
				check_value("tx_full during wr", tx_full, 0);
				tx_q.push_back(w_data);
			end
		end
	end

	// Drive inputs just after the rising edge
	always @(posedge clk)
	begin
		#1;
		if (pop_pending && (rx_q.size() > 0))
			void'(rx_q.pop_front());
		pop_pending = 1'b0;
		rx_empty = (rx_q.size() == 0);
		r_data = rx_empty ? 8'h00 : rx_q[0];
		tx_full = bp_en ? lfsr_bit() : 1'b0;
	end

	////////////////////////////////////////
	// Command and response
	////////////////////////////////////////

	task automatic wait_bytes(input int n);
		int cycles;
		cycles = 0;
		while ((tx_q.size() < n) && (cycles < TIMEOUT))
		begin
			@(posedge clk);
			cycles++;
		end
		if (tx_q.size() < n)
		begin
			$display("Timeout: only %0d of %0d response bytes arrived", tx_q.size(), n);
			$display("TEST FAILED");
			$fatal(1, "Response timeout");
		end
	endtask

	task automatic check_response();
		wait_bytes(dbg_pkg::SNAP_BYTES);
		// Give any stray extra write time to show up
		repeat (5) @(posedge clk);
		check_value("response length", tx_q.size(), dbg_pkg::SNAP_BYTES);
		for (int i = 0; i < dbg_pkg::SNAP_BYTES; i++)
			check_value($sformatf("w_data byte %0d", i), tx_q[i], expected_byte(k, i));
		tx_q.delete();
	endtask

	// Queue one byte, update the model, check the reply if any
	task automatic send_command(input dbg_pkg::byte_t cmd);
		@(negedge clk);
		rx_q.push_back(cmd);
		case (cmd)
			dbg_pkg::CMD_RUN:
				k = HALT_K;
			dbg_pkg::CMD_STEP:
				if (k < HALT_K)
					k++;
			dbg_pkg::CMD_CLEAR:
				k = 0;
			default:
				return;
		endcase
		check_response();
	endtask

	////////////////////////////////////////
	// Tests
	////////////////////////////////////////

	task automatic idle_then_clear();
		// Quiet link while nothing arrives
		repeat (20)
		begin
			@(negedge clk);
			check_value("rd", rd, 0);
			check_value("wr", wr, 0);
		end
		send_command(dbg_pkg::CMD_CLEAR);
	endtask

	task automatic three_steps();
		repeat (3)
			send_command(dbg_pkg::CMD_STEP);
	endtask

	task automatic run_to_halt();
		send_command(dbg_pkg::CMD_RUN);
		// Halted pipe ignores the step
		send_command(dbg_pkg::CMD_STEP);
	endtask

	task automatic unknown_byte();
		send_command(dbg_pkg::CMD_CLEAR);
		send_command(dbg_pkg::CMD_STEP);
		send_command(8'h41);
		// No reply to an unknown byte
		repeat (20) @(posedge clk);
		check_value("bytes after unknown byte", tx_q.size(), 0);
		send_command(dbg_pkg::CMD_STEP);
	endtask

	task automatic back_pressure();
		bp_en = 1'b1;
		send_command(dbg_pkg::CMD_CLEAR);
		repeat (4)
			send_command(dbg_pkg::CMD_STEP);
		send_command(dbg_pkg::CMD_RUN);
		bp_en = 1'b0;
	endtask

	initial
	begin
		rst_n = 1'b0;
		r_data = 8'h00;
		rx_empty = 1'b1;
		tx_full = 1'b0;
		bp_en = 1'b0;
		pop_pending = 1'b0;
		lfsr = 32'h03f58cc4;
		k = 0;
		repeat (2) @(posedge clk);
		#1 rst_n = 1'b1;
		idle_then_clear();
		three_steps();
		run_to_halt();
		unknown_byte();
		back_pressure();
		if (DUT.u_debug_ctrl.u_asserts.fail_count == 0)
		begin
			$display("TEST OK");
			$finish;
		end
		else
		begin
			$display("TEST FAILED");
			$fatal(1, "Assertion failures seen");
		end
	end

endmodule

`default_nettype wire

// File: src.f
dbg_pkg.sv
snap_if.sv
pc_pipe.sv
snapshot_buffer.sv
debug_ctrl.sv
debug_unit.sv
tb_debug_unit_asserts.sv
tb_debug_unit.sv

// File: Bender.yml
package:
  name: debug_unit

sources:
  - dbg_pkg.sv
  - snap_if.sv
  - pc_pipe.sv
  - snapshot_buffer.sv
  - debug_ctrl.sv
  - debug_unit.sv
  - target: test
    files:
      - tb_debug_unit_asserts.sv
      - tb_debug_unit.sv
